// File: filelist.f
+incdir+testbench
hdl/daqPkg.sv
hdl/daqConfigIf.sv
hdl/commandDecoder.sv
hdl/triggerHoldGen.sv
hdl/eventPacker.sv
hdl/daqTop.sv
testbench/daqTb.sv

// File: Bender.yml
package:
  name: daqCore

sources:
  - files:
      - hdl/daqPkg.sv
      - hdl/daqConfigIf.sv
      - hdl/commandDecoder.sv
      - hdl/triggerHoldGen.sv
      - hdl/eventPacker.sv
      - hdl/daqTop.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/daqTb.sv

// File: testbench/daqTbTasks.svh
`ifndef DAQ_TB_TASKS_SVH
`define DAQ_TB_TASKS_SVH

////////////////////
// Stimulus helpers
////////////////////
function automatic int unsigned randBelow(input int unsigned n);
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return (lcgState >> 16) % n; // Upper bits mix better
endfunction

// Expected coincidence result for one mode
function automatic bit expectFire(input coincidMode_t mode, input trigPattern_t p);
    case (mode)
        coincidOr:  return p.trig2 | p.trig1 | p.trig0;
        coincidAnd: return p.trig2 & p.trig1 & p.trig0;
        coincidExt: return p.ext;
        default:    return p.trig0;
    endcase
endfunction

task automatic step(input int n); // Ends 1 ns after a rising edge
    repeat (n) @(posedge Clk);
    #1;
endtask

task automatic sendCmd(input logic [opcodeWidth-1:0] op,
                       input logic [valueWidth-1:0] value);
    ctrlWord  = {op, value};
    ctrlValid = 1'b1;
    step(1);
    ctrlValid = 1'b0;
endtask

task automatic applyTrig(input trigPattern_t p); // Pins are active low
    outTrig2b = ~p.trig2;
    outTrig1b = ~p.trig1;
    outTrig0b = ~p.trig0;
    extTrigb  = ~p.ext;
endtask

// Cycles from the trigger edge to HOLD, then HOLD width
task automatic measureHold(output int rise, output int width);
    rise  = 0;
    width = 0;
    @(negedge Clk);
    while (!hold && rise < 300) begin
        rise++;
        @(negedge Clk);
    end
    while (hold && width < 300) begin
        width++;
        @(negedge Clk);
    end
    if (rise >= 300 || width >= 300) begin
        errorCount++;
        $display("HOLD pulse never completed, stopped waiting at %0t", $time);
    end
endtask

task automatic fireEvent(input trigPattern_t p, output int rise, output int width);
    applyTrig(p);
    measureHold(rise, width);
    step(1);
    applyTrig('0);
    step(3 + randBelow(4)); // Random gap
endtask

task automatic checkQuiet(input int cycles); // No HOLD and no data expected
    bit sawHold;
    sawHold = 1'b0;
    repeat (cycles) begin
        @(negedge Clk);
        sawHold |= hold;
    end
    step(1);
    if (sawHold || words.size() != 0) begin
        errorCount++;
        $display("Trigger was counted although it should be ignored, at %0t", $time);
        words.delete();
    end
endtask

////////////////////
// Compare tasks
////////////////////
task automatic checkWord(input string what, input logic [wordWidth-1:0] got,
                         input logic [wordWidth-1:0] exp);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic checkHoldWidth(input string what, input logic [delayWidth-1:0] got,
                              input logic [delayWidth-1:0] exp);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("error %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
    end
endtask

task automatic checkLost(input string what, input logic [lostWidth-1:0] got,
                         input logic [lostWidth-1:0] exp);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("error %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

// Waits for one word pair and checks both words
task automatic checkEvent(input trigPattern_t p, input logic [eventNumWidth-1:0] num);
    int waited;
    waited = 0;
    while (words.size() < 2 && waited < 60) begin
        step(1);
        waited++;
    end
    if (words.size() < 2) begin
        errorCount++;
        $display("Word pair for event %0d never arrived, at %0t", num, $time);
    end else begin
        checkWord("data word 0", words.pop_front(), {expHeader, 4'h0, p});
        checkWord("event number", words.pop_front(), num);
    end
endtask

////////////////////
// Directed tests
////////////////////
task automatic testResetAndCommands();
    int rise;
    int width;
    applyTrig(4'b0010); // Acquisition still off
    step(3);
    applyTrig('0);
    checkQuiet(30);
    checkLost("lost events after reset", lostEvents, 8'd0);
    sendCmd(opAcq, 12'd1);
    fireEvent(4'b0010, rise, width);
    checkHoldWidth("default hold delay", 8'(rise), 8'd7); // 4 + 3
    checkHoldWidth("default hold time", 8'(width), 8'd16);
    checkEvent(4'b0010, 16'd0);
    expNum = 1;
endtask

task automatic testHoldTiming();
    int rise;
    int width;
    int unsigned delayVal;
    int unsigned timeVal;
    repeat (4) begin
        delayVal = randBelow(16);
        timeVal  = 1 + randBelow(20);
        sendCmd(opHoldDelay, 12'(delayVal));
        sendCmd(opHoldTime, 12'(timeVal));
        fireEvent(4'b0010, rise, width);
        checkHoldWidth("hold delay", 8'(rise), 8'(delayVal + 3));
        checkHoldWidth("hold time", 8'(width), 8'(timeVal));
        checkEvent(4'b0010, expNum);
        expNum++;
    end
endtask

task automatic testCoincidence();
    trigPattern_t patterns [6] = '{4'b0010, 4'b0100, 4'b0001, 4'b0110, 4'b1110, 4'b1111};
    int rise;
    int width;
    sendCmd(opHoldDelay, 12'd2); // Short holds keep this test quick
    sendCmd(opHoldTime, 12'd3);
    for (int m = 0; m < 4; m++) begin
        sendCmd(opCoincid, 12'(m));
        foreach (patterns[i]) begin
            if (expectFire(coincidMode_t'(m), patterns[i])) begin
                fireEvent(patterns[i], rise, width);
                checkEvent(patterns[i], expNum);
                expNum++;
            end else begin
                applyTrig(patterns[i]);
                checkQuiet(12);
                applyTrig('0);
                step(4);
            end
        end
    end
endtask

task automatic testNumbering();
    logic [headerWidth-1:0] newHeader;
    int rise;
    int width;
    newHeader = expHeader ^ 8'(1 + randBelow(255)); // Always differs
    sendCmd(opCoincid, 12'(coincidOr));
    sendCmd(opAcq, 12'd0);
    applyTrig(4'b0010);
    step(3);
    applyTrig('0);
    checkQuiet(15);
    sendCmd(opHeader, 12'(newHeader));
    sendCmd(opAcq, 12'd1);
    expHeader = newHeader;
    expNum    = 0; // Restarted run
    repeat (3) begin
        fireEvent(4'b0010, rise, width);
        checkEvent(4'b0010, expNum);
        expNum++;
    end
endtask

task automatic testBackPressure();
    logic [eventNumWidth-1:0] base;
    int rise;
    int width;
    base     = expNum;
    dataFull = 1'b1;
    repeat (6) fireEvent(4'b0010, rise, width); // Last two find the buffer full
    checkLost("lost events while full", lostEvents, 8'd2);
    dataFull = 1'b0;
    for (int i = 0; i < 4; i++) begin
        checkEvent(4'b0010, 16'(base + i));
    end
    step(10);
    if (words.size() != 0) begin
        errorCount++;
        $display("Dropped events still produced data words, at %0t", $time);
        words.delete();
    end
    fireEvent(4'b0010, rise, width);
    checkEvent(4'b0010, 16'(base + 6)); // Numbers 4 and 5 skipped
    checkLost("lost events after drain", lostEvents, 8'd2);
    expNum = base + 7;
endtask

`endif

// File: testbench/daqTb.sv
`timescale 1ns/10ps

module daqTb;
    import daqPkg::*;

    localparam int clkPeriod = 8;
    // Rough cycle budget per test
    localparam int runCycles = 10 + 120 + 240 + 600 + 120 + 240;
    localparam int watchdogTime = 2 * runCycles * clkPeriod;

    logic                   Clk;
    logic                   reset;
    logic                   ctrlValid;
    logic [wordWidth-1:0]   ctrlWord;
    logic                   outTrig0b;
    logic                   outTrig1b;
    logic                   outTrig2b;
    logic                   extTrigb;
    logic                   hold;
    logic                   dataFull;
    logic                   dataWrite;
    logic [wordWidth-1:0]   dataWord;
    logic [lostWidth-1:0]   lostEvents;

    logic [wordWidth-1:0]       words [$];             // Captured data words
    int                         errorCount = 0;
    int                         checkCount = 0;
    logic [31:0]                lcgState = 32'd35998;
    logic [headerWidth-1:0]     expHeader = 8'hA5;     // Header after reset
    logic [eventNumWidth-1:0]   expNum = '0;

    `include "daqTbTasks.svh"

    daqTop u_dut (
        .Clk        (Clk),
        .reset      (reset),
        .ctrlValid  (ctrlValid),
        .ctrlWord   (ctrlWord),
        .outTrig0b  (outTrig0b),
        .outTrig1b  (outTrig1b),
        .outTrig2b  (outTrig2b),
        .extTrigb   (extTrigb),
        .hold       (hold),
        .dataFull   (dataFull),
        .dataWrite  (dataWrite),
        .dataWord   (dataWord),
        .lostEvents (lostEvents)
    );

    initial begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    ////////////////////
    // Data capture
    ////////////////////
    always @(negedge Clk) begin // Outputs settled mid cycle
        if (!reset && dataWrite) begin
            if (dataFull) begin
                errorCount++;
                $display("error %0t: data written while the host FIFO is full", $time);
            end
            words.push_back(dataWord);
        end
    end

    initial begin
        #(watchdogTime);
        $display("Watchdog expired after %0t, tests did not finish", $time);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        reset     = 1'b1;
        ctrlValid = 1'b0;
        ctrlWord  = '0;
        dataFull  = 1'b0;
        applyTrig('0); // All triggers idle high
        repeat (8) @(posedge Clk);
        #1 reset = 1'b0;
        step(2);
        testResetAndCommands();
        testHoldTiming();
        testCoincidence();
        testNumbering();
        testBackPressure();
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: hdl/daqTop.sv
`timescale 1ns/10ps

module daqTop (
    input  logic                           Clk,
    input  logic                           reset,
    // Host commands
    input  logic                           ctrlValid,
    input  logic [daqPkg::wordWidth-1:0]   ctrlWord,
    // Chip and external triggers
    input  logic                           outTrig0b,
    input  logic                           outTrig1b,
    input  logic                           outTrig2b,
    input  logic                           extTrigb,
    output logic                           hold,       // To the chips
    // Host data FIFO
    input  logic                           dataFull,
    output logic                           dataWrite,
    output logic [daqPkg::wordWidth-1:0]   dataWord,
    output logic [daqPkg::lostWidth-1:0]   lostEvents
);
    import daqPkg::*;

    logic           eventValid;
    eventRecord_t   eventRecord;

    daqConfigIf cfgBus ();

    ////////////////////
    // Decode
    ////////////////////
    commandDecoder u_decoder (
        .Clk       (Clk),
        .reset     (reset),
        .ctrlValid (ctrlValid),
        .ctrlWord  (ctrlWord),
        .cfg       (cfgBus.decoder)
    );

    ////////////////////
    // Trigger and hold
    ////////////////////
    triggerHoldGen u_trigger (
        .Clk         (Clk),
        .reset       (reset),
        .outTrig0b   (outTrig0b),
        .outTrig1b   (outTrig1b),
        .outTrig2b   (outTrig2b),
        .extTrigb    (extTrigb),
        .cfg         (cfgBus.trigger),
        .hold        (hold),
        .eventValid  (eventValid),
        .eventRecord (eventRecord)
    );

    // Records to host words
    eventPacker u_packer (
        .Clk         (Clk),
        .reset       (reset),
        .eventValid  (eventValid),
        .eventRecord (eventRecord),
        .dataFull    (dataFull),
        .cfg         (cfgBus.packer),
        .dataWrite   (dataWrite),
        .dataWord    (dataWord),
        .lostEvents  (lostEvents)
    );

endmodule

// File: hdl/eventPacker.sv
`timescale 1ns/10ps

module eventPacker (
    input  logic                           Clk,
    input  logic                           reset,
    input  logic                           eventValid,
    input  daqPkg::eventRecord_t           eventRecord,
    input  logic                           dataFull,    // Host FIFO level
    daqConfigIf.packer                     cfg,
    output logic                           dataWrite,
    output logic [daqPkg::wordWidth-1:0]   dataWord,
    output logic [daqPkg::lostWidth-1:0]   lostEvents
);
    import daqPkg::*;

    // Depth is a power of two so pointers wrap on their own
    typedef logic [$clog2(eventBufferDepth)-1:0] ptr_t;

    eventRecord_t                              buffer [eventBufferDepth];
    ptr_t                                      wrPtr;
    ptr_t                                      rdPtr;
    logic [$clog2(eventBufferDepth+1)-1:0]     fill;    // Records waiting
    logic                                      wordSel; // 0 pattern word, 1 number word
    logic                                      push;
    logic                                      pop;
    logic                                      drop;
    eventRecord_t                              head;

    ////////////////////
    // Record buffer
    ////////////////////
    assign drop = eventValid && (fill == eventBufferDepth); // Full buffer loses record
    assign push = eventValid && !drop;
    assign pop  = dataWrite && wordSel;                     // Second word retires entry

    always_ff @(posedge Clk) begin
        if (push) begin
            buffer[wrPtr] <= eventRecord;
        end
    end

    assign head = buffer[rdPtr];

    ////////////////////
    // Word serializer
    ////////////////////
    assign dataWrite = (fill != '0) && !dataFull; // Stall while host FIFO is full

    always_comb begin
        if (wordSel) begin
            dataWord = head.eventNum;
        end else begin
            dataWord = {cfg.header, {padWidth{1'b0}}, head.pattern};
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            fill       <= '0;
            wordSel    <= 1'b0;
            lostEvents <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (dataWrite) begin
                wordSel <= ~wordSel;
            end

            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;     // Both or neither
            endcase

            // Saturate at all ones
            if (drop && lostEvents != '1) begin
                lostEvents <= lostEvents + 1'b1;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // No write into a full FIFO
    aStallOnFull: assert property (@(posedge Clk) disable iff (reset)
        dataFull |-> !dataWrite);

    // Pending record is not overwritten while it waits
    aPendingKept: assert property (@(posedge Clk) disable iff (reset)
        dataFull && fill != '0 |=> $stable(head));

    // Pointers agree with the fill count
    aNoOverrun: assert property (@(posedge Clk) disable iff (reset)
        fill <= eventBufferDepth && ptr_t'(wrPtr - rdPtr) == ptr_t'(fill));

endmodule

// File: hdl/triggerHoldGen.sv
`timescale 1ns/10ps

module triggerHoldGen (
    input  logic                   Clk,
    input  logic                   reset,
    input  logic                   outTrig0b,   // Chip triggers, active low
    input  logic                   outTrig1b,
    input  logic                   outTrig2b,
    input  logic                   extTrigb,    // External pin, active low
    daqConfigIf.trigger            cfg,
    output logic                   hold,
    output logic                   eventValid,  // One cycle after HOLD falls
    output daqPkg::eventRecord_t   eventRecord
);
    import daqPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stDelay,   // Waiting holdDelay cycles
        stHold,    // HOLD high for holdTime cycles
        stReport   // Hand record to packer
    } state_t;

    trigPattern_t               trigRaw;
    trigPattern_t               trigMeta;   // First synchronizer flop
    trigPattern_t               trigSync;   // Second flop feeds the logic
    logic                       coinc;
    logic                       coincPrev;
    logic                       coincEdge;
    logic                       accept;
    logic                       acqPrev;
    logic                       acqRise;
    logic [delayWidth-1:0]      timer;      // Shared by delay and hold phases
    logic [eventNumWidth-1:0]   eventCount; // Next number to hand out
    state_t                     state;

    ////////////////////
    // Trigger input
    ////////////////////
    assign trigRaw.trig2 = ~outTrig2b;
    assign trigRaw.trig1 = ~outTrig1b;
    assign trigRaw.trig0 = ~outTrig0b;
    assign trigRaw.ext   = ~extTrigb;

    // Coincidence select
    always_comb begin
        coinc = 1'b0;
        case (cfg.coincidMode)
            coincidOr:    coinc = trigSync.trig2 | trigSync.trig1 | trigSync.trig0;
            coincidAnd:   coinc = trigSync.trig2 & trigSync.trig1 & trigSync.trig0;
            coincidExt:   coinc = trigSync.ext;
            coincidTrig0: coinc = trigSync.trig0;
            default:      coinc = 1'b0;
        endcase
    end

    assign coincEdge = coinc & ~coincPrev;
    assign accept    = coincEdge && cfg.acqOn && state == stIdle; // Busy edges dropped
    assign acqRise   = cfg.acqOn & ~acqPrev;

    ////////////////////
    // Hold FSM
    ////////////////////
    always_ff @(posedge Clk) begin
        if (reset) begin
            trigMeta   <= '0;
            trigSync   <= '0;
            coincPrev  <= 1'b0;
            acqPrev    <= 1'b0;
            eventCount <= '0;
            timer      <= '0;
            state      <= stIdle;
        end else begin
            trigMeta  <= trigRaw;
            trigSync  <= trigMeta;
            coincPrev <= coinc;
            acqPrev   <= cfg.acqOn;

            // New run restarts numbering
            if (acqRise) begin
                eventCount <= accept ? eventNumWidth'(1) : '0;
            end else if (accept) begin
                eventCount <= eventCount + 1'b1;
            end

            case (state)
                stIdle: begin
                    if (accept && cfg.holdDelay == '0) begin
                        state <= stHold; // No delay so HOLD starts now
                        timer <= cfg.holdTime;
                    end else if (accept) begin
                        state <= stDelay;
                        timer <= cfg.holdDelay;
                    end
                end
                stDelay: begin
                    if (timer <= 1) begin
                        state <= stHold;
                        timer <= cfg.holdTime;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                stHold: begin
                    if (timer <= 1) begin
                        state <= stReport; // Zero width acts as one
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Pattern and number captured at the accepted edge
    always_ff @(posedge Clk) begin
        if (accept) begin
            eventRecord.pattern  <= trigSync;
            eventRecord.eventNum <= acqRise ? '0 : eventCount;
        end
    end

    assign hold       = (state == stHold);
    assign eventValid = (state == stReport);

    ////////////////////
    // Checks
    ////////////////////

    // Edge without acquisition starts no hold sequence
    aNoHoldWithoutAcq: assert property (@(posedge Clk) disable iff (reset)
        state == stIdle && coincEdge && !cfg.acqOn |=> state == stIdle);

    aValidPulse: assert property (@(posedge Clk) disable iff (reset)
        eventValid |=> !eventValid);

endmodule

// File: hdl/commandDecoder.sv
`timescale 1ns/10ps

module commandDecoder (
    input  logic                           Clk,
    input  logic                           reset,
    input  logic                           ctrlValid,  // One cycle per command
    input  logic [daqPkg::wordWidth-1:0]   ctrlWord,
    daqConfigIf.decoder                    cfg
);
    import daqPkg::*;

    logic [opcodeWidth-1:0] opcode;
    logic [valueWidth-1:0]  value;

    ////////////////////
    // Field split
    ////////////////////
    assign opcode = ctrlWord[wordWidth-1 -: opcodeWidth]; // Bits 15:12
    assign value  = ctrlWord[valueWidth-1:0];             // Bits 11:0

    ////////////////////
    // Config registers
    ////////////////////

    // One register per opcode
    // Everything else keeps its last value
    always_ff @(posedge Clk) begin
        if (reset) begin
            cfg.coincidMode <= coincidOr;
            cfg.holdDelay   <= defaultHoldDelay;
            cfg.holdTime    <= defaultHoldTime;
            cfg.header      <= defaultHeader;
            cfg.acqOn       <= 1'b0; // Idle until the host starts a run
        end else if (ctrlValid) begin
            case (opcode)
                opCoincid: begin
                    cfg.coincidMode <= coincidMode_t'(value[1:0]);
                end
                opHoldDelay: begin
                    cfg.holdDelay <= value[delayWidth-1:0];
                end
                opHoldTime: begin
                    cfg.holdTime <= value[delayWidth-1:0];
                end
                opHeader: begin
                    cfg.header <= value[headerWidth-1:0];
                end
                opAcq: begin
                    cfg.acqOn <= value[0];
                end
                default: begin
                    // Unknown opcode
                end
            endcase
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // A known opcode shows its masked value one cycle later
    property pFieldLoad(op, logic [valueWidth-1:0] field, logic [valueWidth-1:0] mask);
        @(posedge Clk) disable iff (reset)
            ctrlValid && opcode == op |=> field == ($past(value) & mask);
    endproperty

    aCoincidLoad: assert property (pFieldLoad(opCoincid,
        valueWidth'(cfg.coincidMode), valueWidth'(2'b11)));
    aDelayLoad: assert property (pFieldLoad(opHoldDelay,
        valueWidth'(cfg.holdDelay), valueWidth'(8'hFF)));
    aTimeLoad: assert property (pFieldLoad(opHoldTime,
        valueWidth'(cfg.holdTime), valueWidth'(8'hFF)));
    aHeaderLoad: assert property (pFieldLoad(opHeader,
        valueWidth'(cfg.header), valueWidth'(8'hFF)));
    aAcqLoad: assert property (pFieldLoad(opAcq,
        valueWidth'(cfg.acqOn), valueWidth'(1'b1)));

endmodule

// File: hdl/daqConfigIf.sv
`timescale 1ns/10ps

// Decoded acquisition settings
// Written by the command decoder and read by the trigger and packer stages
interface daqConfigIf;

    daqPkg::coincidMode_t               coincidMode; // Trigger combination
    logic [daqPkg::delayWidth-1:0]      holdDelay;   // Cycles from edge to HOLD
    logic [daqPkg::delayWidth-1:0]      holdTime;    // HOLD width in cycles
    logic [daqPkg::headerWidth-1:0]     header;      // Upper byte of data word 0
    logic                               acqOn;       // Acquisition running

    // Register side
    modport decoder (
        output coincidMode, holdDelay, holdTime, header, acqOn
    );

    // Hold timing needs everything but the header
    modport trigger (
        input coincidMode, holdDelay, holdTime, acqOn
    );

    modport packer (
        input header
    );

endinterface

// File: hdl/daqPkg.sv
package daqPkg;

    ////////////////////
    // Widths and sizes
    ////////////////////
    localparam int wordWidth        = 16; // Control and data words
    localparam int opcodeWidth      = 4;  // Top bits of a control word
    localparam int valueWidth       = 12; // Payload bits of a control word
    localparam int headerWidth      = 8;
    localparam int delayWidth       = 8;  // Hold delay and hold time counters
    localparam int eventNumWidth    = 16;
    localparam int lostWidth        = 8;  // Saturating drop counter
    localparam int eventBufferDepth = 4;  // Records waiting in the packer

    ////////////////////
    // Command opcodes
    ////////////////////
    localparam logic [opcodeWidth-1:0] opCoincid   = 4'd1;
    localparam logic [opcodeWidth-1:0] opHoldDelay = 4'd2;
    localparam logic [opcodeWidth-1:0] opHoldTime  = 4'd3;
    localparam logic [opcodeWidth-1:0] opHeader    = 4'd4;
    localparam logic [opcodeWidth-1:0] opAcq       = 4'd5; // Value bit 0 starts or stops

    // Values loaded at reset
    localparam logic [delayWidth-1:0]  defaultHoldDelay = 8'd4;
    localparam logic [delayWidth-1:0]  defaultHoldTime  = 8'd16;
    localparam logic [headerWidth-1:0] defaultHeader    = 8'hA5;

    ////////////////////
    // Types
    ////////////////////

    // Which trigger combination starts a hold
    typedef enum logic [1:0] {
        coincidOr    = 2'd0, // Any chip trigger
        coincidAnd   = 2'd1, // All three chip triggers
        coincidExt   = 2'd2, // External trigger only
        coincidTrig0 = 2'd3  // Chip trigger 0 only
    } coincidMode_t;

    // Active high trigger levels seen at the edge
    typedef struct packed {
        logic trig2;
        logic trig1;
        logic trig0;
        logic ext;   // LSB
    } trigPattern_t;

    // Zero bits between header and pattern in data word 0
    localparam int padWidth = wordWidth - headerWidth - $bits(trigPattern_t);

    // One accepted event as handed to the packer
    typedef struct packed {
        trigPattern_t               pattern;
        logic [eventNumWidth-1:0]   eventNum;
    } eventRecord_t;

endpackage
